/* common/dragonPkg.sv */
/* dragon collision subsystem shared definitions
   board geometry, FIFO sizing, move opcodes and the beat/report structs */
package dragonPkg;

    // board position byte holds the row in the upper nibble and the column in the lower
    localparam int POS_W = 8;
    localparam int NIBBLE_W = 4;

    // dragon chain
    localparam int NUM_SEGMENTS = 7;
    localparam int LEN_W = 3;  // holds 1..7

    // segment buffer and matching credit pool
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;
    localparam int CREDIT_W = 3;  // counts 0..FIFO_DEPTH

    // every segment sits here after reset (row 8, column 8)
    localparam logic [POS_W-1:0] HEAD_START = 8'h88;

    // per-frame head move; rows grow downward, columns grow rightward
    typedef enum logic [2:0] {
        MOVE_NONE  = 3'd0,
        MOVE_UP    = 3'd1,  // row - 1
        MOVE_DOWN  = 3'd2,  // row + 1
        MOVE_LEFT  = 3'd3,  // column - 1
        MOVE_RIGHT = 3'd4   // column + 1
    } moveDir_t;

    // producer FSM
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        MOVE   = 2'd1,
        STREAM = 2'd2
    } bodyState_t;

    // one streamed segment
    typedef struct packed {
        logic [POS_W-1:0] pos;
        logic             lastSeg;  // final segment of the frame
    } segmentBeat_t;

    // positions of the other objects on the board
    typedef struct packed {
        logic [POS_W-1:0] player;
        logic [POS_W-1:0] sword;
        logic [POS_W-1:0] sheep;
    } objectPos_t;

    // per-frame collision flags
    typedef struct packed {
        logic playerHit;
        logic swordHit;
        logic sheepHit;
    } collisionReport_t;

endpackage

/* design/collisionChecker.sv */
/* collision checker
   compares each popped segment with player, sword and sheep, keeps sticky
   flags over the frame and reports them after the last segment */
module collisionChecker import dragonPkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             notEmpty,
    input  segmentBeat_t     headBeat,
    input  objectPos_t       objects,
    input  logic             pause,
    output logic             pop,
    output logic             reportValid,
    output collisionReport_t report
);

    collisionReport_t hits;       // this segment against the three objects
    collisionReport_t flags;      // sticky over the frame
    collisionReport_t flagsNext;

    assign pop = notEmpty && !pause;

    always_comb begin
        hits.playerHit = (headBeat.pos == objects.player);
        hits.swordHit  = (headBeat.pos == objects.sword);
        hits.sheepHit  = (headBeat.pos == objects.sheep);
    end

    // flags restart from zero once the report has gone out
    always_comb begin
        flagsNext = reportValid ? '0 : flags;
        if (pop) begin
            flagsNext = flagsNext | hits;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            flags <= '0;
            reportValid <= 1'b0;
        end else begin
            flags <= flagsNext;
            reportValid <= pop && headBeat.lastSeg; // one-cycle pulse
        end
    end

    // holds the frame's final flags while reportValid is high
    assign report = flags;

endmodule

/* design/dragon/dragonBody.sv */
/* dragon body producer
   holds the segment chain, applies the frame move and streams the
   active segments to the buffer under credit control */
module dragonBody import dragonPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         frameStart,
    input  moveDir_t     move,
    input  logic [LEN_W-1:0] dragonLength,
    input  logic         creditReturn,
    output logic         frameReady,
    output logic         beatValid,
    output segmentBeat_t beat
);

    bodyState_t state;
    moveDir_t moveReg;                     // move latched at frame accept
    logic [LEN_W-1:0] lastIdx;             // index of the final active segment
    logic [LEN_W-1:0] segIdx;              // segment being streamed
    logic [CREDIT_W-1:0] credits;
    logic [POS_W-1:0] segs [NUM_SEGMENTS]; // segs[0] is the head

    // one head step with each nibble wrapping on its own
    function automatic logic [POS_W-1:0] stepHead(input logic [POS_W-1:0] pos,
                                                  input moveDir_t dir);
        logic [NIBBLE_W-1:0] row;
        logic [NIBBLE_W-1:0] col;
        row = pos[POS_W-1:NIBBLE_W];
        col = pos[NIBBLE_W-1:0];
        case (dir)
            MOVE_UP:    row = row - 1'b1;
            MOVE_DOWN:  row = row + 1'b1;
            MOVE_LEFT:  col = col - 1'b1;
            MOVE_RIGHT: col = col + 1'b1;
            default: ;
        endcase
        return {row, col};
    endfunction

    assign frameReady = (state == IDLE);
    assign beatValid = (state == STREAM) && (credits != '0);
    assign beat.pos = segs[segIdx];
    assign beat.lastSeg = (segIdx == lastIdx);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= IDLE;
            segIdx <= '0;
            for (int i = 0; i < NUM_SEGMENTS; i++) begin
                segs[i] <= HEAD_START;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (frameStart) begin
                        moveReg <= move;
                        // a length of zero still streams the head
                        lastIdx <= (dragonLength == '0) ? '0 : dragonLength - 1'b1;
                        state <= MOVE;
                    end
                end
                MOVE: begin
                    if (moveReg != MOVE_NONE) begin
                        for (int i = NUM_SEGMENTS - 1; i > 0; i--) begin
                            segs[i] <= segs[i-1]; // each segment takes its leader's place
                        end
                        segs[0] <= stepHead(segs[0], moveReg);
                    end
                    segIdx <= '0;
                    state <= STREAM;
                end
                STREAM: begin
                    if (beatValid) begin
                        if (beat.lastSeg) begin
                            state <= IDLE;
                        end else begin
                            segIdx <= segIdx + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // one credit goes out per beat sent and comes back per pop downstream
    always_ff @(posedge clk) begin
        if (!reset) begin
            credits <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            credits <= credits - CREDIT_W'(beatValid) + CREDIT_W'(creditReturn);
        end
    end

    creditsBounded: assert property (@(posedge clk) disable iff (!reset)
        credits <= CREDIT_W'(FIFO_DEPTH));

endmodule

/* design/dragonCollisionUnit.sv */
/* dragon collision unit top
   body feeds segments through the FIFO to the checker */
module dragonCollisionUnit import dragonPkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             frameStart,
    input  moveDir_t         move,
    input  logic [LEN_W-1:0] dragonLength,
    input  objectPos_t       objects,
    input  logic             pause,
    output logic             frameReady,
    output logic             reportValid,
    output collisionReport_t report
);

    logic         beatValid;
    segmentBeat_t beat;
    logic         creditReturn;
    logic         notEmpty;
    segmentBeat_t headBeat;
    logic         pop;

    dragonBody body0 (
        .clk          (clk),
        .reset        (reset),
        .frameStart   (frameStart),
        .move         (move),
        .dragonLength (dragonLength),
        .creditReturn (creditReturn),
        .frameReady   (frameReady),
        .beatValid    (beatValid),
        .beat         (beat)
    );

    segmentFifo fifo0 (
        .clk          (clk),
        .reset        (reset),
        .beatValid    (beatValid),
        .beat         (beat),
        .pop          (pop),
        .notEmpty     (notEmpty),
        .headBeat     (headBeat),
        .creditReturn (creditReturn)
    );

    collisionChecker checker0 (
        .clk         (clk),
        .reset       (reset),
        .notEmpty    (notEmpty),
        .headBeat    (headBeat),
        .objects     (objects),
        .pause       (pause),
        .pop         (pop),
        .reportValid (reportValid),
        .report      (report)
    );

endmodule

/* design/segmentFifo.sv */
/* segment buffer
   small circular FIFO between body and checker, one credit back per pop */
module segmentFifo import dragonPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         beatValid,
    input  segmentBeat_t beat,
    input  logic         pop,
    output logic         notEmpty,
    output segmentBeat_t headBeat,
    output logic         creditReturn
);

    segmentBeat_t mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wrPtr;
    logic [FIFO_PTR_W-1:0] rdPtr;
    logic [CREDIT_W-1:0] count;  // same range as the credit pool

    assign notEmpty = (count != '0);
    assign headBeat = mem[rdPtr];

    // entry written on each push
    always_ff @(posedge clk) begin
        if (beatValid) begin
            mem[wrPtr] <= beat;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (beatValid) begin
                wrPtr <= wrPtr + 1'b1; // wraps at FIFO_DEPTH
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + CREDIT_W'(beatValid) - CREDIT_W'(pop);
        end
    end

    // freed slot goes back to the producer a cycle after the pop
    always_ff @(posedge clk) begin
        if (!reset) begin
            creditReturn <= 1'b0;
        end else begin
            creditReturn <= pop;
        end
    end

    // credits upstream should make overflow impossible
    noPushWhenFull: assert property (@(posedge clk) disable iff (!reset)
        beatValid |-> (count != CREDIT_W'(FIFO_DEPTH)));

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (!reset)
        pop |-> (count != '0));

endmodule

/* filelist.f */
common/dragonPkg.sv
design/dragon/dragonBody.sv
design/segmentFifo.sv
design/collisionChecker.sv
design/dragonCollisionUnit.sv
verif/dragonCollisionTb.sv

/* verif/dragonCollisionTb.sv */
/* dragon collision unit testbench
   directed and random frames checked against a model of the dragon chain */
module dragonCollisionTb import dragonPkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int WATCHDOG_CYCLES = 40 * 30; // 40 frames of 30 cycles

    logic             clk;
    logic             reset;
    logic             frameStart;
    moveDir_t         move;
    logic [LEN_W-1:0] dragonLength;
    objectPos_t       objects;
    logic             pause;
    logic             frameReady;
    logic             reportValid;
    collisionReport_t report;

    int errors;
    logic [POS_W-1:0] model [NUM_SEGMENTS]; // model[0] is the head

    dragonCollisionUnit dut0 (
        .clk          (clk),
        .reset        (reset),
        .frameStart   (frameStart),
        .move         (move),
        .dragonLength (dragonLength),
        .objects      (objects),
        .pause        (pause),
        .frameReady   (frameReady),
        .reportValid  (reportValid),
        .report       (report)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // head position after one move with rows and columns wrapping mod 16
    function automatic logic [POS_W-1:0] nextHead(input logic [POS_W-1:0] pos,
                                                  input moveDir_t dir);
        int row;
        int col;
        row = pos[7:4];
        col = pos[3:0];
        case (dir)
            MOVE_UP:    row = (row + 15) % 16;
            MOVE_DOWN:  row = (row + 1) % 16;
            MOVE_LEFT:  col = (col + 15) % 16;
            MOVE_RIGHT: col = (col + 1) % 16;
            default: ;
        endcase
        return POS_W'(row * 16 + col);
    endfunction

    task automatic applyMove(input moveDir_t dir);
        if (dir != MOVE_NONE) begin
            for (int i = NUM_SEGMENTS - 1; i > 0; i--) begin
                model[i] = model[i-1];
            end
            model[0] = nextHead(model[0], dir);
        end
    endtask

    function automatic collisionReport_t expectReport(input int len, input objectPos_t obj);
        collisionReport_t want;
        int active;
        want = '0;
        active = (len == 0) ? 1 : len; // zero length still covers the head
        for (int i = 0; i < active; i++) begin
            if (model[i] == obj.player) want.playerHit = 1'b1;
            if (model[i] == obj.sword) want.swordHit = 1'b1;
            if (model[i] == obj.sheep) want.sheepHit = 1'b1;
        end
        return want;
    endfunction

    // about half the objects land on a segment of the chain
    function automatic logic [POS_W-1:0] pickObjectPos();
        if ($urandom_range(1, 0) == 0) begin
            return model[$urandom_range(NUM_SEGMENTS - 1, 0)];
        end
        return POS_W'($urandom_range(255, 0));
    endfunction

    task automatic checkReport(input string name, input collisionReport_t want,
                               input collisionReport_t got);
        if (got !== want) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, want, got);
        end
    endtask

    task automatic startFrame(input moveDir_t dir, input int len, input objectPos_t obj);
        @(negedge clk);
        while (!frameReady) @(negedge clk);
        @(posedge clk);
        frameStart <= 1'b1;
        move <= dir;
        dragonLength <= LEN_W'(len);
        objects <= obj;
        @(posedge clk);
        frameStart <= 1'b0;
    endtask

    task automatic waitReport(output collisionReport_t got);
        @(negedge clk);
        while (!reportValid) @(negedge clk);
        got = report;
    endtask

    task automatic runFrame(input moveDir_t dir, input int len, input objectPos_t obj,
                            output collisionReport_t got);
        startFrame(dir, len, obj);
        waitReport(got);
    endtask

    task automatic resetStateTest();
        repeat (4) begin
            @(negedge clk);
            if (frameReady !== 1'b1) begin
                errors++;
                $display("error reset state: expected frameReady 1, actual %b", frameReady);
            end
            if (reportValid !== 1'b0) begin
                errors++;
                $display("error reset state: expected reportValid 0, actual %b", reportValid);
            end
        end
    endtask

    task automatic headCollisionTest();
        objectPos_t obj;
        collisionReport_t got;
        obj.player = 8'hF0;
        obj.sword = 8'h00;
        obj.sheep = 8'h0F;
        applyMove(MOVE_UP);
        runFrame(MOVE_UP, 3, obj, got);
        checkReport("head setup", expectReport(3, obj), got);
        applyMove(MOVE_RIGHT);
        obj.player = model[0]; // predicted head
        runFrame(MOVE_RIGHT, 3, obj, got);
        checkReport("head collision", collisionReport_t'(3'b100), got);
        obj.player = 8'hF0;
        runFrame(MOVE_NONE, 3, obj, got);
        checkReport("head clear", collisionReport_t'(3'b000), got);
    endtask

    task automatic inactiveSegmentTest();
        objectPos_t obj;
        collisionReport_t got;
        obj.player = 8'hF0;
        obj.sword = 8'h00;
        obj.sheep = 8'h0F;
        // spread the chain so every segment sits on its own square
        repeat (5) begin
            applyMove(MOVE_DOWN);
            runFrame(MOVE_DOWN, 7, obj, got);
            checkReport("inactive setup", expectReport(7, obj), got);
        end
        obj.sheep = model[5];
        runFrame(MOVE_NONE, 3, obj, got);
        checkReport("inactive length 3", collisionReport_t'(3'b000), got);
        runFrame(MOVE_NONE, 7, obj, got);
        checkReport("inactive length 7", collisionReport_t'(3'b001), got);
    endtask

    task automatic multiObjectTest();
        objectPos_t obj;
        collisionReport_t got;
        obj.player = 8'hF0;
        obj.sword = model[1];
        obj.sheep = model[4];
        runFrame(MOVE_NONE, 7, obj, got);
        checkReport("multi object", collisionReport_t'(3'b011), got);
        checkReport("multi object model", expectReport(7, obj), got);
    endtask

    task automatic backPressureTest();
        objectPos_t obj;
        collisionReport_t got;
        collisionReport_t want;
        int pulses;
        applyMove(MOVE_UP);
        obj.player = model[6];
        obj.sword = 8'h00;
        obj.sheep = model[2];
        want = expectReport(7, obj);
        pulses = 0;
        got = '0;
        @(posedge clk);
        pause <= 1'b1;
        startFrame(MOVE_UP, 7, obj);
        repeat (20) begin
            @(negedge clk);
            if (reportValid) begin
                errors++;
                $display("error back pressure pause: expected reportValid 0, actual %b",
                         reportValid);
            end
        end
        @(posedge clk);
        pause <= 1'b0;
        repeat (25) begin
            @(negedge clk);
            if (reportValid) begin
                pulses++;
                got = report;
            end
        end
        if (pulses != 1) begin
            errors++;
            $display("error back pressure pulses: expected 1, actual %0d", pulses);
        end
        checkReport("back pressure", want, got);
    endtask

    task automatic randomFrameTest();
        moveDir_t dir;
        int len;
        objectPos_t obj;
        collisionReport_t got;
        collisionReport_t want;
        for (int f = 0; f < 30; f++) begin
            dir = moveDir_t'($urandom_range(4, 0));
            len = $urandom_range(7, 0);
            applyMove(dir);
            obj.player = pickObjectPos();
            obj.sword = pickObjectPos();
            obj.sheep = pickObjectPos();
            want = expectReport(len, obj);
            runFrame(dir, len, obj, got);
            checkReport($sformatf("random frame %0d", f), want, got);
        end
    endtask

    initial begin
        void'($urandom(11));
        errors = 0;
        reset = 1'b0;
        frameStart = 1'b0;
        move = MOVE_NONE;
        dragonLength = '0;
        objects = '0;
        pause = 1'b0;
        for (int i = 0; i < NUM_SEGMENTS; i++) begin
            model[i] = HEAD_START;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        resetStateTest();
        headCollisionTest();
        inactiveSegmentTest();
        multiObjectTest();
        backPressureTest();
        randomFrameTest();
        $display("all tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not end within %0d cycles, %0d errors so far",
                 WATCHDOG_CYCLES, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule
